//--- dmem_model.sv
// behavioral data memory; index wraps over MEM_WORDS, one request per cycle, stores give no response
`timescale 1ns/1ps
`include "mem_macros.svh"

module dmem_model (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  busy_i,         // external back-pressure

    input  logic                  head_valid_i,
    input  mem_pkg::mem_cmd_t     head_cmd_i,
    input  mem_pkg::addr_t        head_addr_i,
    input  mem_pkg::bus64_t       head_data_i,
    input  mem_pkg::funct3_t      head_funct3_i,
    input  mem_pkg::reg_t         head_rd_i,

    output logic                  pop_o,
    output logic                  resp_valid_o,
    output mem_pkg::bus64_t       resp_data_o,
    output mem_pkg::reg_t         resp_rd_o
);

    import mem_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);

    bus64_t             mem_q [`MEM_WORDS];
    logic [IDX_W-1:0]   word_idx;
    bus64_t             old_word;
    bus64_t             lane_data;
    bus64_t             load_val;
    bus64_t             st_data;
    logic [7:0]         size_mask;
    logic [7:0]         byte_en;
    bus64_t             wr_word;
    logic               is_load;
    logic               is_store;

    assign pop_o    = head_valid_i && !busy_i;
    assign is_load  = (head_cmd_i == CMD_LOAD);
    assign is_store = (head_cmd_i == CMD_STORE);

    assign word_idx = head_addr_i[IDX_W+2:3];
    assign old_word = mem_q[word_idx];

    // --------------------------------------------------
    // load lane extract
    // --------------------------------------------------
    assign lane_data = old_word >> {head_addr_i[2:0], 3'b000};

    always_comb begin
        case (head_funct3_i[1:0])
            2'd0: load_val = head_funct3_i[2] ? {56'b0, lane_data[7:0]}
                                              : {{56{lane_data[7]}}, lane_data[7:0]};
            2'd1: load_val = head_funct3_i[2] ? {48'b0, lane_data[15:0]}
                                              : {{48{lane_data[15]}}, lane_data[15:0]};
            2'd2: load_val = head_funct3_i[2] ? {32'b0, lane_data[31:0]}
                                              : {{32{lane_data[31]}}, lane_data[31:0]};
            default: load_val = lane_data;
        endcase
    end

    // store byte enables and shifted data
    always_comb begin
        case (head_funct3_i[1:0])
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    assign byte_en = size_mask << head_addr_i[2:0];
    assign st_data = head_data_i << {head_addr_i[2:0], 3'b000};

    // --------------------------------------------------
    // write word for stores and AMOs
    // --------------------------------------------------
    always_comb begin
        wr_word = old_word;
        case (head_cmd_i)
            CMD_STORE: begin
                for (int b = 0; b < 8; b++) begin
                    if (byte_en[b]) wr_word[8*b +: 8] = st_data[8*b +: 8];
                end
            end
            CMD_SWAP: wr_word = head_data_i;
            CMD_ADD:  wr_word = old_word + head_data_i;
            CMD_XOR:  wr_word = old_word ^ head_data_i;
            CMD_AND:  wr_word = old_word & head_data_i;
            CMD_OR:   wr_word = old_word | head_data_i;
            CMD_MIN:  wr_word = ($signed(old_word) < $signed(head_data_i)) ? old_word : head_data_i;
            CMD_MAX:  wr_word = ($signed(old_word) > $signed(head_data_i)) ? old_word : head_data_i;
            CMD_MINU: wr_word = (old_word < head_data_i) ? old_word : head_data_i;
            CMD_MAXU: wr_word = (old_word > head_data_i) ? old_word : head_data_i;
            default:  wr_word = old_word;  // loads keep the word
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (pop_o && !is_load) begin
            mem_q[word_idx] <= wr_word;
        end
    end

    // --------------------------------------------------
    // in-order response
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= pop_o && !is_store;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            resp_data_o <= is_load ? load_val : old_word;  // AMO returns old value
            resp_rd_o   <= head_rd_i;
        end
    end

endmodule

//--- mem_macros.svh
// sizes only; MEM_QDEPTH also sets the issuer's initial credit count, keep MEM_WORDS a power of two
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// --------------------------------------------------
// request queue
// --------------------------------------------------
`define MEM_QDEPTH 4                // entries, equal to the starting credits

// --------------------------------------------------
// memory model
// --------------------------------------------------
`define MEM_WORDS 256               // 64-bit words, index wraps on higher address bits

// --------------------------------------------------
// addressing
// --------------------------------------------------
`define MEM_ADDR_W 40               // physical address bits

`endif

//--- mem_pkg.sv
// shared types of the data-memory path; LR/SC is not encoded, command values follow the dcache
`include "mem_macros.svh"

package mem_pkg;

    // plain vectors with a meaning
    typedef logic [63:0]              bus64_t;
    typedef logic [`MEM_ADDR_W-1:0]   addr_t;
    typedef logic [4:0]               reg_t;       // destination register, used as tag
    typedef logic [4:0]               mem_cmd_t;   // dcache command
    typedef logic [2:0]               funct3_t;    // size in [1:0], unsigned in [2]

    typedef enum logic [1:0] {
        MEM_LOAD,
        MEM_STORE,
        MEM_AMO
    } mem_op_t;

    typedef enum logic [3:0] {
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX,
        AMO_MINU,
        AMO_MAXU
    } amo_op_t;

    typedef enum logic {
        ISS_RESET,
        ISS_RUN
    } issuer_state_t;

    // cache command encodings
    localparam mem_cmd_t CMD_LOAD  = 5'b00000;
    localparam mem_cmd_t CMD_STORE = 5'b00001;
    localparam mem_cmd_t CMD_SWAP  = 5'b00100;
    localparam mem_cmd_t CMD_ADD   = 5'b01000;
    localparam mem_cmd_t CMD_XOR   = 5'b01001;
    localparam mem_cmd_t CMD_OR    = 5'b01010;
    localparam mem_cmd_t CMD_AND   = 5'b01011;
    localparam mem_cmd_t CMD_MIN   = 5'b01100;
    localparam mem_cmd_t CMD_MAX   = 5'b01101;
    localparam mem_cmd_t CMD_MINU  = 5'b01110;
    localparam mem_cmd_t CMD_MAXU  = 5'b01111;

endpackage

//--- mem_req_issuer.sv
// issue stage; AMOs are always doubleword, misaligned ops trap and are dropped, no IO window or LR/SC
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_req_issuer (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    // pipeline side
    input  logic                  valid_i,
    input  logic                  kill_i,
    input  mem_pkg::mem_op_t      mem_op_i,
    input  mem_pkg::amo_op_t      amo_op_i,
    input  mem_pkg::funct3_t      funct3_i,
    input  mem_pkg::reg_t         rd_i,
    input  mem_pkg::bus64_t       data_rs1_i,
    input  mem_pkg::bus64_t       data_rs2_i,
    input  mem_pkg::bus64_t       imm_i,

    // queue side
    input  logic                  credit_i,     // one pulse per queue pop
    output logic                  push_o,
    output mem_pkg::mem_cmd_t     cmd_o,
    output mem_pkg::addr_t        addr_o,
    output mem_pkg::bus64_t       data_o,
    output mem_pkg::funct3_t      funct3_o,
    output mem_pkg::reg_t         rd_o,

    output logic                  lock_o,
    output logic                  xcpt_ma_o
);

    import mem_pkg::*;

    localparam int CNT_W = $clog2(`MEM_QDEPTH + 1);

    issuer_state_t      state_q;
    logic [CNT_W-1:0]   credits_q;
    bus64_t             addr_sum;
    logic [1:0]         acc_size;
    logic               misaligned;
    logic               go;

    // --------------------------------------------------
    // state and lock
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ISS_RESET;
        end else begin
            state_q <= ISS_RUN;         // one cycle out of reset
        end
    end

    assign lock_o = (state_q == ISS_RESET) || (credits_q == '0);

    // --------------------------------------------------
    // command decode
    // --------------------------------------------------
    always_comb begin
        case (mem_op_i)
            MEM_STORE: cmd_o = CMD_STORE;
            MEM_AMO: begin
                case (amo_op_i)
                    AMO_SWAP: cmd_o = CMD_SWAP;
                    AMO_ADD:  cmd_o = CMD_ADD;
                    AMO_XOR:  cmd_o = CMD_XOR;
                    AMO_AND:  cmd_o = CMD_AND;
                    AMO_OR:   cmd_o = CMD_OR;
                    AMO_MIN:  cmd_o = CMD_MIN;
                    AMO_MAX:  cmd_o = CMD_MAX;
                    AMO_MINU: cmd_o = CMD_MINU;
                    AMO_MAXU: cmd_o = CMD_MAXU;
                    default:  cmd_o = CMD_LOAD;
                endcase
            end
            default:   cmd_o = CMD_LOAD;
        endcase
    end

    // address and alignment
    assign addr_sum = data_rs1_i + imm_i;
    assign addr_o   = (mem_op_i == MEM_AMO) ? data_rs1_i[`MEM_ADDR_W-1:0]
                                            : addr_sum[`MEM_ADDR_W-1:0];

    assign acc_size = (mem_op_i == MEM_AMO) ? 2'd3 : funct3_i[1:0];

    always_comb begin
        case (acc_size)
            2'd0:    misaligned = 1'b0;
            2'd1:    misaligned = addr_o[0];
            2'd2:    misaligned = |addr_o[1:0];
            default: misaligned = |addr_o[2:0];
        endcase
    end

    // --------------------------------------------------
    // accept and push
    // --------------------------------------------------
    assign go        = valid_i && !kill_i && !lock_o;
    assign push_o    = go && !misaligned;
    assign xcpt_ma_o = go && misaligned;   // same cycle, nothing pushed

    assign funct3_o = (mem_op_i == MEM_AMO) ? funct3_t'(3'd3) : funct3_i;
    assign data_o   = data_rs2_i;
    assign rd_o     = rd_i;

    // credits track free queue entries
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            credits_q <= CNT_W'(`MEM_QDEPTH);
        end else if (push_o && !credit_i) begin
            credits_q <= credits_q - 1'b1;
        end else if (credit_i && !push_o) begin
            credits_q <= credits_q + 1'b1;
        end
    end

    // queue must hand back exactly one credit per entry taken
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        credits_q <= CNT_W'(`MEM_QDEPTH))
        else $error("issuer credit count above queue depth");

endmodule

//--- mem_req_queue.sv
// request FIFO; relies on the issuer's credits to never overflow, credit_o lags each pop by one cycle
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_req_queue (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  push_i,
    input  mem_pkg::mem_cmd_t     cmd_i,
    input  mem_pkg::addr_t        addr_i,
    input  mem_pkg::bus64_t       data_i,
    input  mem_pkg::funct3_t      funct3_i,
    input  mem_pkg::reg_t         rd_i,

    input  logic                  pop_i,
    output logic                  head_valid_o,
    output mem_pkg::mem_cmd_t     head_cmd_o,
    output mem_pkg::addr_t        head_addr_o,
    output mem_pkg::bus64_t       head_data_o,
    output mem_pkg::funct3_t      head_funct3_o,
    output mem_pkg::reg_t         head_rd_o,
    output logic                  credit_o
);

    import mem_pkg::*;

    localparam int PTR_W = $clog2(`MEM_QDEPTH);
    localparam int CNT_W = $clog2(`MEM_QDEPTH + 1);

    // payload storage
    mem_cmd_t   cmd_q    [`MEM_QDEPTH];
    addr_t      addr_q   [`MEM_QDEPTH];
    bus64_t     data_q   [`MEM_QDEPTH];
    funct3_t    funct3_q [`MEM_QDEPTH];
    reg_t       rd_q     [`MEM_QDEPTH];

    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`MEM_QDEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            cmd_q[wr_ptr_q]    <= cmd_i;
            addr_q[wr_ptr_q]   <= addr_i;
            data_q[wr_ptr_q]   <= data_i;
            funct3_q[wr_ptr_q] <= funct3_i;
            rd_q[wr_ptr_q]     <= rd_i;
        end
    end

    // --------------------------------------------------
    // pointers, occupancy and credit return
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;
            if (push_i) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop_i)  rd_ptr_q <= ptr_next(rd_ptr_q);
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

    assign head_valid_o  = (count_q != '0);
    assign head_cmd_o    = cmd_q[rd_ptr_q];
    assign head_addr_o   = addr_q[rd_ptr_q];
    assign head_data_o   = data_q[rd_ptr_q];
    assign head_funct3_o = funct3_q[rd_ptr_q];
    assign head_rd_o     = rd_q[rd_ptr_q];

    // issuer credits guard against overflow
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        push_i |-> count_q < CNT_W'(`MEM_QDEPTH))
        else $error("push into full request queue");

    // memory model may only pop a valid head
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> count_q != '0)
        else $error("pop from empty request queue");

endmodule

//--- mem_subsys_tb.sv
// self-checking testbench; expects responses in accept order and at most 1024 outstanding answers
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_tb;

    import mem_pkg::*;

    localparam int N_RANDOM     = 200;
    localparam int N_OPS        = 49 + N_RANDOM;       // directed plus random operations
    localparam int WD_CYCLES    = N_OPS * (`MEM_QDEPTH + 10) + 100;
    localparam int SB_DEPTH     = 1024;
    localparam int DRAIN_CYCLES = 2 * `MEM_QDEPTH + 4;  // full queue empties well within this

    logic       clk_i = 1'b0;
    logic       rstn_i;
    logic       valid_i, kill_i, dmem_busy_i;
    mem_op_t    mem_op_i;
    amo_op_t    amo_op_i;
    funct3_t    funct3_i;
    reg_t       rd_i;
    bus64_t     data_rs1_i, data_rs2_i, imm_i;
    logic       lock_o, xcpt_ma_o, resp_valid_o;
    bus64_t     resp_data_o;
    reg_t       resp_rd_o;

    int         seed = 32'h8155_4a6e;
    int         errors = 0;
    int         checks = 0;
    int         resp_checks = 0;
    logic       rand_busy = 1'b0;             // busy toggles randomly in the mixed phase
    logic       last_stalled;
    reg_t       next_rd = '0;
    bus64_t     ref_mem [`MEM_WORDS];
    bus64_t     sb_data [SB_DEPTH];
    reg_t       sb_tag  [SB_DEPTH];
    int         sb_wr = 0;
    int         sb_rd = 0;
    bus64_t     exp_data;
    reg_t       exp_tag;

    always #10 clk_i = ~clk_i;

    mem_subsys_top dut_i (.*);

    // --------------------------------------------------
    // scoreboard and response checks
    // --------------------------------------------------
    assign exp_data = sb_data[sb_rd % SB_DEPTH];
    assign exp_tag  = sb_tag[sb_rd % SB_DEPTH];

    always @(posedge clk_i) begin
        if (rstn_i && resp_valid_o) begin
            sb_rd       <= sb_rd + 1;
            resp_checks <= resp_checks + 1;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o |-> (sb_wr != sb_rd) && (resp_data_o == exp_data) && (resp_rd_o == exp_tag))
        else begin
            errors++;
            $display("** Error at %0t: response rd %0d data %h, expected rd %0d data %h",
                     $time, $sampled(resp_rd_o), $sampled(resp_data_o),
                     $sampled(exp_tag), $sampled(exp_data));
        end

    // killed or locked ops never trap
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (kill_i || lock_o) |-> !xcpt_ma_o)
        else begin
            errors++;
            $display("** Error at %0t: xcpt_ma_o raised for a killed or locked op", $time);
        end

    task automatic check_flag(input logic got, input logic exp, input string what);
        assert (got === exp) checks++;
        else begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic expect_resp(input bus64_t data, input reg_t tag);
        sb_data[sb_wr % SB_DEPTH] = data;
        sb_tag[sb_wr % SB_DEPTH]  = tag;
        sb_wr++;
    endtask

    // --------------------------------------------------
    // reference memory rules
    // --------------------------------------------------
    function automatic int word_index(input addr_t a);
        return int'((a >> 3) % `MEM_WORDS);
    endfunction

    function automatic bus64_t load_value(input bus64_t word, input int off, input funct3_t f3);
        int     nbytes;
        bus64_t v;
        nbytes = 1 << f3[1:0];
        v = '0;
        for (int b = 0; b < nbytes; b++) begin
            v[8*b +: 8] = word[8*(off+b) +: 8];
        end
        if (!f3[2] && v[8*nbytes-1]) begin
            v = v | (~64'h0 << (8 * nbytes));   // sign fill
        end
        return v;
    endfunction

    function automatic bus64_t store_merge(input bus64_t word, input bus64_t data,
                                           input int off, input funct3_t f3);
        bus64_t w;
        w = word;
        for (int b = 0; b < (1 << f3[1:0]); b++) begin
            w[8*(off+b) +: 8] = data[8*b +: 8];
        end
        return w;
    endfunction

    function automatic bus64_t amo_result(input amo_op_t op, input bus64_t old, input bus64_t src);
        case (op)
            AMO_SWAP: return src;
            AMO_ADD:  return old + src;
            AMO_XOR:  return old ^ src;
            AMO_AND:  return old & src;
            AMO_OR:   return old | src;
            AMO_MIN:  return ($signed(src) < $signed(old)) ? src : old;
            AMO_MAX:  return ($signed(src) > $signed(old)) ? src : old;
            AMO_MINU: return (src < old) ? src : old;
            default:  return (src > old) ? src : old;    // maxu
        endcase
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // accept happens on the edge that follows this task's return
    task automatic send(input mem_op_t op, input amo_op_t amo, input funct3_t f3, input bus64_t rs1,
                        input bus64_t rs2, input bus64_t imm, input logic kill);
        addr_t      addr;
        funct3_t    size_f3;
        logic       misal;
        bus64_t     old;
        int         idx;
        @(posedge clk_i);
        next_rd = (next_rd == 5'd31) ? 5'd1 : next_rd + 5'd1;
        valid_i    <= 1'b1;
        kill_i     <= kill;
        mem_op_i   <= op;
        amo_op_i   <= amo;
        funct3_i   <= f3;
        rd_i       <= next_rd;
        data_rs1_i <= rs1;
        data_rs2_i <= rs2;
        imm_i      <= imm;
        if (rand_busy) dmem_busy_i <= ($random(seed) % 3) == 0;
        last_stalled = 1'b0;
        @(negedge clk_i);
        while (lock_o && !kill) begin                 // hold until a credit comes back
            last_stalled = 1'b1;
            @(posedge clk_i);
            if (rand_busy) dmem_busy_i <= ($random(seed) % 3) == 0;
            @(negedge clk_i);
        end
        addr    = (op == MEM_AMO) ? addr_t'(rs1) : addr_t'(rs1 + imm);
        size_f3 = (op == MEM_AMO) ? funct3_t'(3'd3) : f3;
        misal   = (addr % (1 << size_f3[1:0])) != 0;
        check_flag(xcpt_ma_o, !kill && misal, "xcpt_ma_o");
        if (!kill && !misal) begin
            idx = word_index(addr);
            old = ref_mem[idx];
            case (op)
                MEM_LOAD:  expect_resp(load_value(old, int'(addr[2:0]), size_f3), next_rd);
                MEM_STORE: ref_mem[idx] = store_merge(old, rs2, int'(addr[2:0]), size_f3);
                default: begin
                    expect_resp(old, next_rd);        // amo answers with the old word
                    ref_mem[idx] = amo_result(amo, old, rs2);
                end
            endcase
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            valid_i <= 1'b0;
            kill_i  <= 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        rand_busy = 1'b0;
        waited    = 0;
        @(posedge clk_i);
        valid_i     <= 1'b0;
        kill_i      <= 1'b0;
        dmem_busy_i <= 1'b0;
        while ((sb_rd < sb_wr) && (waited < DRAIN_CYCLES)) begin
            @(negedge clk_i);
            waited++;
        end
        idle(`MEM_QDEPTH + 3);                          // trailing stores and credits
    endtask

    task automatic random_mix(input int n);
        logic [31:0]    r;
        mem_op_t        op;
        funct3_t        f3;
        bus64_t         target;
        bus64_t         imm;
        int             size;
        rand_busy = 1'b1;
        for (int i = 0; i < n; i++) begin
            r      = $random(seed);
            op     = mem_op_t'(r % 3);
            f3     = funct3_t'((r >> 8) % 7);
            size   = (op == MEM_AMO) ? 3 : int'(f3[1:0]);
            target = {53'b0, r[23:19], r[26:24] & ~3'((1 << size) - 1)};
            if (r[31:29] == 3'd0) target[2:0] = r[26:24];   // occasional misaligned
            imm    = (op == MEM_AMO) ? 64'h0 : {59'b0, r[28:27], 3'b000};
            send(op, amo_op_t'((r >> 4) % 9), f3, target - imm,
                 {$random(seed), $random(seed)}, imm, r[15:13] == 3'd0);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        rstn_i      = 1'b0;
        valid_i     = 1'b0;
        kill_i      = 1'b0;
        dmem_busy_i = 1'b0;
        mem_op_i    = MEM_LOAD;
        amo_op_i    = AMO_SWAP;
        funct3_i    = '0;
        rd_i        = '0;
        data_rs1_i  = '0;
        data_rs2_i  = '0;
        imm_i       = '0;
        for (int i = 0; i < `MEM_WORDS; i++) ref_mem[i] = '0;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        check_flag(lock_o, 1'b1, "lock_o in reset state");
        @(negedge clk_i);
        check_flag(lock_o, 1'b0, "lock_o");
        check_flag(resp_valid_o, 1'b0, "resp_valid_o");
        check_flag(xcpt_ma_o, 1'b0, "xcpt_ma_o");

        // store then every load size, lowest and highest lane
        send(MEM_STORE, AMO_SWAP, 3'd3, 64'h0f8, 64'hf1e2_d3c4_b5a6_9788, 64'h8, 1'b0);
        for (int f = 0; f < 7; f++) begin
            send(MEM_LOAD, AMO_SWAP, funct3_t'(f), 64'h100, '0, '0, 1'b0);
            send(MEM_LOAD, AMO_SWAP, funct3_t'(f), 64'h108 - (1 << f[1:0]), '0, '0, 1'b0);
        end
        send(MEM_STORE, AMO_SWAP, 3'd0, 64'h103, 64'h5a, '0, 1'b0);
        send(MEM_LOAD, AMO_SWAP, 3'd3, 64'h100, '0, '0, 1'b0);

        // each amo, then a load of the combined word
        send(MEM_STORE, AMO_SWAP, 3'd3, 64'h200, 64'h8000_0000_0000_0005, '0, 1'b0);
        for (int a = 0; a < 9; a++) begin
            send(MEM_AMO, amo_op_t'(a), 3'd1, 64'h200, {$random(seed), $random(seed)}, '0, 1'b0);
            send(MEM_LOAD, AMO_SWAP, 3'd3, 64'h200, '0, '0, 1'b0);
        end

        // misaligned and killed ops leave memory alone
        send(MEM_LOAD, AMO_SWAP, 3'd1, 64'h101, '0, '0, 1'b0);
        send(MEM_STORE, AMO_SWAP, 3'd2, 64'h0fa, '1, 64'h8, 1'b0);
        send(MEM_LOAD, AMO_SWAP, 3'd6, 64'h106, '0, '0, 1'b0);
        send(MEM_AMO, AMO_ADD, 3'd0, 64'h204, 64'h1, '0, 1'b0);   // byte funct3 is ignored
        send(MEM_STORE, AMO_SWAP, 3'd3, 64'h100, '1, '0, 1'b1);
        send(MEM_AMO, AMO_SWAP, 3'd3, 64'h200, '1, '0, 1'b1);
        send(MEM_LOAD, AMO_SWAP, 3'd3, 64'h100, '0, '0, 1'b0);
        send(MEM_LOAD, AMO_SWAP, 3'd3, 64'h200, '0, '0, 1'b0);
        drain();

        // back-pressure fills the queue exactly
        @(posedge clk_i);
        dmem_busy_i <= 1'b1;
        for (int i = 0; i < `MEM_QDEPTH; i++) begin
            send(MEM_LOAD, AMO_SWAP, 3'd3, 64'h100 + 8 * i, '0, '0, 1'b0);
            check_flag(last_stalled, 1'b0, "stall before queue full");
        end
        idle(1);
        @(negedge clk_i);
        check_flag(lock_o, 1'b1, "lock_o with full queue");
        idle(3);
        @(negedge clk_i);
        check_flag(lock_o, 1'b1, "lock_o under sustained busy");
        @(posedge clk_i);
        dmem_busy_i <= 1'b0;
        send(MEM_LOAD, AMO_SWAP, 3'd2, 64'h204, '0, '0, 1'b0);
        drain();

        random_mix(N_RANDOM);
        drain();

        assert (sb_wr == sb_rd) checks++;
        else begin
            errors++;
            $display("scoreboard out of step, %0d responses expected but %0d received",
                     sb_wr, sb_rd);
        end
        $display("checks: %0d, errors: %0d", checks + resp_checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- mem_subsys_top.f
+incdir+.
mem_pkg.sv
mem_req_issuer.sv
mem_req_queue.sv
dmem_model.sv
mem_subsys_top.sv
mem_subsys_tb.sv

//--- mem_subsys_top.sv
// data-memory subsystem; results come back in accept order with two cycles minimum latency
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  valid_i,
    input  logic                  kill_i,
    input  mem_pkg::mem_op_t      mem_op_i,
    input  mem_pkg::amo_op_t      amo_op_i,
    input  mem_pkg::funct3_t      funct3_i,
    input  mem_pkg::reg_t         rd_i,
    input  mem_pkg::bus64_t       data_rs1_i,
    input  mem_pkg::bus64_t       data_rs2_i,
    input  mem_pkg::bus64_t       imm_i,
    input  logic                  dmem_busy_i,

    output logic                  lock_o,
    output logic                  xcpt_ma_o,
    output logic                  resp_valid_o,
    output mem_pkg::bus64_t       resp_data_o,
    output mem_pkg::reg_t         resp_rd_o
);

    import mem_pkg::*;

    // issuer to queue
    logic       push;
    mem_cmd_t   cmd;
    addr_t      addr;
    bus64_t     data;
    funct3_t    funct3;
    reg_t       rd;
    logic       credit;

    // queue to memory model
    logic       head_valid;
    mem_cmd_t   head_cmd;
    addr_t      head_addr;
    bus64_t     head_data;
    funct3_t    head_funct3;
    reg_t       head_rd;
    logic       pop;

    mem_req_issuer u_issuer (
        .clk_i (clk_i), .rstn_i (rstn_i), .valid_i (valid_i), .kill_i (kill_i),
        .mem_op_i (mem_op_i), .amo_op_i (amo_op_i), .funct3_i (funct3_i), .rd_i (rd_i),
        .data_rs1_i (data_rs1_i), .data_rs2_i (data_rs2_i), .imm_i (imm_i),
        .credit_i (credit), .push_o (push), .cmd_o (cmd), .addr_o (addr), .data_o (data),
        .funct3_o (funct3), .rd_o (rd), .lock_o (lock_o), .xcpt_ma_o (xcpt_ma_o)
    );

    mem_req_queue u_queue (
        .clk_i (clk_i), .rstn_i (rstn_i), .push_i (push), .cmd_i (cmd), .addr_i (addr),
        .data_i (data), .funct3_i (funct3), .rd_i (rd), .pop_i (pop),
        .head_valid_o (head_valid), .head_cmd_o (head_cmd), .head_addr_o (head_addr),
        .head_data_o (head_data), .head_funct3_o (head_funct3), .head_rd_o (head_rd),
        .credit_o (credit)
    );

    dmem_model u_dmem (
        .clk_i (clk_i), .rstn_i (rstn_i), .busy_i (dmem_busy_i),
        .head_valid_i (head_valid), .head_cmd_i (head_cmd), .head_addr_i (head_addr),
        .head_data_i (head_data), .head_funct3_i (head_funct3), .head_rd_i (head_rd),
        .pop_o (pop), .resp_valid_o (resp_valid_o), .resp_data_o (resp_data_o),
        .resp_rd_o (resp_rd_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_subsys_tb \
    -f mem_subsys_top.f -o mem_subsys_sim \
    && ./obj_dir/mem_subsys_sim > sim.log 2>&1 \
    || echo "SIMULATION FAILED: build or run error" >> sim.log

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
